// File: graph_settings.svh
/*
 * graph settings: screen timing, coordinate sizes and register map
 */

`ifndef GRAPH_SETTINGS_SVH
`define GRAPH_SETTINGS_SVH

// visible area
`define H_RES        640
`define V_RES        480

// full scan incl. blanking
`define H_TOTAL      800
`define V_TOTAL      525

// sync windows, active low
`define H_SYNC_START 656
`define H_SYNC_END   752
`define V_SYNC_START 490
`define V_SYNC_END   492

`define CORDW        12     // screen and maths coordinate width
`define X_OFFS       320    // screen column of maths origin
`define Y_OFFS       239    // screen row of maths origin

`define PLOT_LAT     4      // scan position to rgb out

// apb byte addresses
`define REG_CTRL     4'h0
`define REG_BG       4'h4
`define REG_CURVE    4'h8
`define REG_AXES     4'hC

`endif

// File: graph_pkg.sv
/*
 * graph types: function select and 12-bit colour
 */

`default_nettype none

package graph_pkg;

    // which curve gets drawn
    typedef enum logic [1:0] {
        FUNC_OFF    = 2'd0,
        FUNC_LINE   = 2'd1,
        FUNC_SQUARE = 2'd2,
        FUNC_CUBE   = 2'd3
    } func_sel_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

endpackage

`default_nettype wire

// File: display_timing.sv
/*
 * display timing for 640x480 at 60 Hz
 * scan counters with registered sync, data enable and frame start
 */

`default_nettype none

`include "graph_settings.svh"

module display_timing (
    input  wire logic              clk_pix,
    input  wire logic              reset,
    output      logic [`CORDW-1:0] sx,          // screen column
    output      logic [`CORDW-1:0] sy,          // screen row
    output      logic              hsync,       // active low
    output      logic              vsync,       // active low
    output      logic              de,          // visible area
    output      logic              frame_start  // high at (0,0)
);

    logic [`CORDW-1:0] nx, ny;  // position for next cycle
    logic              line_end;

    // next scan position
    always_comb begin
        line_end = (sx == `CORDW'(`H_TOTAL - 1));
        nx = line_end ? '0 : sx + 1'b1;
        if (!line_end)
            ny = sy;
        else if (sy == `CORDW'(`V_TOTAL - 1))
            ny = '0;  // last line, wrap to top
        else
            ny = sy + 1'b1;
    end

    // flags decoded from the next position so they land with the counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx          <= '0;
            sy          <= '0;
            hsync       <= 1'b1;  // (0,0) lies outside both sync windows
            vsync       <= 1'b1;
            de          <= 1'b1;  // and inside the visible area
            frame_start <= 1'b1;
        end else begin
            sx          <= nx;
            sy          <= ny;
            hsync       <= ~(nx >= `CORDW'(`H_SYNC_START) &&
                             nx <  `CORDW'(`H_SYNC_END));
            vsync       <= ~(ny >= `CORDW'(`V_SYNC_START) &&
                             ny <  `CORDW'(`V_SYNC_END));
            de          <= (nx < `CORDW'(`H_RES)) && (ny < `CORDW'(`V_RES));
            frame_start <= (nx == '0) && (ny == '0);
        end
    end

endmodule

`default_nettype wire

// File: graph_regs.sv
/*
 * graph control registers on apb
 * software writes shadows, live copies follow at frame start
 */

`default_nettype none

`include "graph_settings.svh"

module graph_regs (
    input  wire logic               clk_pix,
    input  wire logic               reset,
    input  wire logic               psel,
    input  wire logic               penable,
    input  wire logic               pwrite,
    input  wire logic [3:0]         paddr,
    input  wire logic [31:0]        pwdata,
    output      logic [31:0]        prdata,
    output      logic               pslverr,
    input  wire logic               frame_start,
    output      graph_pkg::func_sel_t live_func,
    output      logic [3:0]         live_shift,
    output      graph_pkg::rgb12_t  live_bg,
    output      graph_pkg::rgb12_t  live_curve,
    output      graph_pkg::rgb12_t  live_axes
);

    import graph_pkg::*;

    // software visible copies
    func_sel_t   sh_func;
    logic [3:0]  sh_shift;
    rgb12_t      sh_bg, sh_curve, sh_axes;

    logic        wr_en, rd_en;
    logic        addr_ok;
    logic [31:0] rd_word;

    assign wr_en = psel && penable && pwrite;   // access phase only
    assign rd_en = psel && penable && !pwrite;

    // address decode and readback mux
    always_comb begin
        addr_ok = 1'b1;
        rd_word = '0;  // unused bits read zero
        case (paddr)
            `REG_CTRL: begin
                rd_word[1:0] = sh_func;
                rd_word[7:4] = sh_shift;
            end
            `REG_BG:    rd_word[11:0] = sh_bg;
            `REG_CURVE: rd_word[11:0] = sh_curve;
            `REG_AXES:  rd_word[11:0] = sh_axes;
            default:    addr_ok = 1'b0;
        endcase
    end

    assign prdata  = rd_en ? rd_word : '0;
    assign pslverr = psel && penable && !addr_ok;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sh_func    <= FUNC_OFF;
            sh_shift   <= '0;
            sh_bg      <= '0;
            sh_curve   <= '0;
            sh_axes    <= '0;
            live_func  <= FUNC_OFF;
            live_shift <= '0;
            live_bg    <= '0;
            live_curve <= '0;
            live_axes  <= '0;
        end else begin
            if (wr_en) begin
                case (paddr)
                    `REG_CTRL: begin
                        sh_func  <= func_sel_t'(pwdata[1:0]);
                        sh_shift <= pwdata[7:4];
                    end
                    `REG_BG:    sh_bg    <= rgb12_t'(pwdata[11:0]);
                    `REG_CURVE: sh_curve <= rgb12_t'(pwdata[11:0]);
                    `REG_AXES:  sh_axes  <= rgb12_t'(pwdata[11:0]);
                    default: ;  // bad address writes nothing
                endcase
            end
            // all live settings switch together, from pixel (0,0)
            if (frame_start) begin
                live_func  <= sh_func;
                live_shift <= sh_shift;
                live_bg    <= sh_bg;
                live_curve <= sh_curve;
                live_axes  <= sh_axes;
            end
        end
    end

endmodule

`default_nettype wire

// File: func_plot.sv
/*
 * function plotter: screen position to curve and axis hits
 * three register stages, sync and de delayed to match
 */

`default_nettype none

`include "graph_settings.svh"

module func_plot (
    input  wire logic                 clk_pix,
    input  wire logic                 reset,
    input  wire logic [`CORDW-1:0]    sx,
    input  wire logic [`CORDW-1:0]    sy,
    input  wire logic                 hsync,
    input  wire logic                 vsync,
    input  wire logic                 de,
    input  wire graph_pkg::func_sel_t live_func,
    input  wire logic [3:0]           live_shift,
    output      logic                 on_curve,
    output      logic                 on_axis,
    output      logic                 hsync_d,
    output      logic                 vsync_d,
    output      logic                 de_d
);

    import graph_pkg::*;

    localparam int FW = 3 * `CORDW;  // wide enough for x cubed

    logic signed [`CORDW-1:0]   x1, y1, y2;   // maths coords per stage
    logic                       axis1, axis2;
    logic signed [2*`CORDW-1:0] sq;
    logic signed [FW-1:0]       cube, fx, fx2;
    func_sel_t                  func2;
    logic [2:0]                 hs_pipe, vs_pipe, de_pipe;

    // stage 1: centre the origin, y grows upwards
    always_ff @(posedge clk_pix) begin
        x1    <= $signed(sx - `CORDW'(`X_OFFS));
        y1    <= $signed(`CORDW'(`Y_OFFS) - sy);
        axis1 <= (sx == `CORDW'(`X_OFFS)) || (sy == `CORDW'(`Y_OFFS));
    end

    // f(x) at full width, arithmetic shifts keep the sign
    always_comb begin
        sq   = x1 * x1;
        cube = sq * x1;
        case (live_func)
            FUNC_LINE:   fx = x1;
            FUNC_SQUARE: fx = sq >>> live_shift;
            FUNC_CUBE:   fx = cube >>> {live_shift, 1'b0};  // twice the shift
            default:     fx = '0;
        endcase
    end

    // stage 2: settings sampled with their pixel
    always_ff @(posedge clk_pix) begin
        fx2   <= fx;
        func2 <= live_func;
        y2    <= y1;
        axis2 <= axis1;
    end

    // stage 3: hit test
    always_ff @(posedge clk_pix) begin
        on_curve <= (func2 != FUNC_OFF) && (fx2 == y2);
        on_axis  <= axis2;
    end

    // sync and de ride alongside
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hs_pipe <= '1;  // syncs idle high
            vs_pipe <= '1;
            de_pipe <= '0;
        end else begin
            hs_pipe <= {hs_pipe[1:0], hsync};
            vs_pipe <= {vs_pipe[1:0], vsync};
            de_pipe <= {de_pipe[1:0], de};
        end
    end

    assign hsync_d = hs_pipe[2];
    assign vsync_d = vs_pipe[2];
    assign de_d    = de_pipe[2];

endmodule

`default_nettype wire

// File: pixel_color.sv
/*
 * colour stage: picks axes, curve or background colour
 * and registers rgb with the matching syncs
 */

`default_nettype none

module pixel_color (
    input  wire logic              clk_pix,
    input  wire logic              reset,
    input  wire logic              on_curve,
    input  wire logic              on_axis,
    input  wire logic              hsync_d,
    input  wire logic              vsync_d,
    input  wire logic              de_d,
    input  wire graph_pkg::rgb12_t live_bg,
    input  wire graph_pkg::rgb12_t live_curve,
    input  wire graph_pkg::rgb12_t live_axes,
    output      logic              vga_hsync,
    output      logic              vga_vsync,
    output      logic              vga_de,
    output      logic [3:0]        vga_r,
    output      logic [3:0]        vga_g,
    output      logic [3:0]        vga_b
);

    import graph_pkg::*;

    rgb12_t pix;  // colour before the output register

    // priority: axes over curve over background
    always_comb begin
        if (!de_d)
            pix = '0;  // black in blanking
        else if (on_axis)
            pix = live_axes;
        else if (on_curve)
            pix = live_curve;
        else
            pix = live_bg;
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_de    <= de_d;
            vga_r     <= pix.r;
            vga_g     <= pix.g;
            vga_b     <= pix.b;
        end
    end

endmodule

`default_nettype wire

// File: graph_top.sv
/*
 * function graphing video generator, 640x480
 * timing, apb registers, plotter and colour stage
 */

`default_nettype none

`include "graph_settings.svh"

module graph_top (
    input  wire logic        clk_pix,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [3:0]  paddr,
    input  wire logic [31:0] pwdata,
    output      logic [31:0] prdata,
    output      logic        pslverr,
    output      logic        vga_hsync,
    output      logic        vga_vsync,
    output      logic [3:0]  vga_r,
    output      logic [3:0]  vga_g,
    output      logic [3:0]  vga_b,
    output      logic        vga_de
);

    import graph_pkg::*;

    logic [`CORDW-1:0] sx, sy;
    logic              hsync, vsync, de, frame_start;
    func_sel_t         live_func;
    logic [3:0]        live_shift;
    rgb12_t            live_bg, live_curve, live_axes;
    logic              on_curve, on_axis;
    logic              hsync_d, vsync_d, de_d;  // 3 cycles behind scan

    display_timing timing_inst (
        .clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de, .frame_start
    );

    graph_regs regs_inst (
        .clk_pix, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pslverr, .frame_start,
        .live_func, .live_shift, .live_bg, .live_curve, .live_axes
    );

    func_plot plot_inst (
        .clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de,
        .live_func, .live_shift,
        .on_curve, .on_axis, .hsync_d, .vsync_d, .de_d
    );

    pixel_color color_inst (
        .clk_pix, .reset, .on_curve, .on_axis, .hsync_d, .vsync_d, .de_d,
        .live_bg, .live_curve, .live_axes,
        .vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
    );

endmodule

`default_nettype wire

// File: tb_graph.sv
/*
 * testbench for the function graphing video generator
 * random apb settings each frame with every output pixel checked against a model
 */

`default_nettype none

`include "graph_settings.svh"

module tb_graph;

    timeunit 1ns;
    timeprecision 1ps;

    import graph_pkg::*;

    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 1000;
    localparam int RUN_FRAMES     = 5;
    localparam logic [14:0] IDLE  = 15'h6000;  // syncs high, de low, black

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [14:0] v;     // hsync, vsync, de, r, g, b
    } expect_t;

    logic        clk_pix = 1'b0;
    logic        reset;
    logic        psel, penable, pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pslverr;
    logic        vga_hsync, vga_vsync, vga_de;
    logic [3:0]  vga_r, vga_g, vga_b;

    // model of the register file
    func_sel_t   sh_func, lv_func;
    logic [3:0]  sh_shift, lv_shift;
    rgb12_t      sh_bg, sh_curve, sh_axes;
    rgb12_t      lv_bg, lv_curve, lv_axes;

    int          m_x, m_y, m_frame;     // scan model
    bit          m_run;
    expect_t     exp_q[$];              // PLOT_LAT entries in flight
    int          vid_errs, reg_errs, cycles;

    graph_top DUT (
        .clk_pix, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pslverr,
        .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b, .vga_de
    );

    initial begin
        forever #5 clk_pix = ~clk_pix;
    end

    // stops a run that hangs
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", cycles);
        $display("errors: video %0d, register %0d", vid_errs, reg_errs);
        $display("FAIL: see errors above");
        $finish;
    end

    // y = f(x) in centred maths coordinates with y up
    function automatic bit curve_hit(input int px, input int py);
        longint x, y, fx;
        x = px - `X_OFFS;
        y = `Y_OFFS - py;
        case (lv_func)
            FUNC_LINE:   fx = x;
            FUNC_SQUARE: fx = (x * x) >>> lv_shift;
            FUNC_CUBE:   fx = (x * x * x) >>> (2 * lv_shift);
            default:     return 1'b0;  // no curve drawn
        endcase
        return fx == y;
    endfunction

    function automatic logic [14:0] pixel_expect(input int px, input int py);
        logic   hs, vs, de;
        rgb12_t c;
        hs = !(px >= `H_SYNC_START && px < `H_SYNC_END);
        vs = !(py >= `V_SYNC_START && py < `V_SYNC_END);
        de = (px < `H_RES) && (py < `V_RES);
        if (!de)
            c = '0;
        else if (px == `X_OFFS || py == `Y_OFFS)
            c = lv_axes;                // axes win
        else if (curve_hit(px, py))
            c = lv_curve;
        else
            c = lv_bg;
        return {hs, vs, de, c};
    endfunction

    function automatic bit addr_valid(input logic [3:0] a);
        return a == `REG_CTRL || a == `REG_BG || a == `REG_CURVE || a == `REG_AXES;
    endfunction

    // readback word per register map with unused bits zero
    function automatic logic [31:0] shadow_word(input logic [3:0] a);
        case (a)
            `REG_CTRL:  return {24'd0, sh_shift, 2'd0, sh_func};
            `REG_BG:    return {20'd0, sh_bg};
            `REG_CURVE: return {20'd0, sh_curve};
            `REG_AXES:  return {20'd0, sh_axes};
            default:    return 32'd0;
        endcase
    endfunction

    // apb write entered 1 ns after a rising edge
    task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
        psel    = 1'b1;         // setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = d;
        @(posedge clk_pix);
        #1 penable = 1'b1;      // access phase
        @(negedge clk_pix);
        if (pslverr !== !addr_valid(a)) begin
            reg_errs++;
            $display("ERR %0t: write to 0x%h gave pslverr %b", $time, a, pslverr);
        end
        @(posedge clk_pix);     // write lands here
        case (a)
            `REG_CTRL: begin
                sh_func  = func_sel_t'(d[1:0]);
                sh_shift = d[7:4];
            end
            `REG_BG:    sh_bg    = d[11:0];
            `REG_CURVE: sh_curve = d[11:0];
            `REG_AXES:  sh_axes  = d[11:0];
            default: ;          // bad address stores nothing
        endcase
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] a);
        logic [31:0] want;
        want    = shadow_word(a);   // zero for bad address
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = a;
        @(posedge clk_pix);
        #1 penable = 1'b1;
        @(negedge clk_pix);         // prdata valid mid access cycle
        if (prdata !== want || pslverr !== !addr_valid(a)) begin
            reg_errs++;
            $display("ERR %0t: read 0x%h expected %h/%b got %h/%b", $time, a,
                     want, !addr_valid(a), prdata, pslverr);
        end
        @(posedge clk_pix);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic readback_all();
        read_reg(`REG_CTRL);
        read_reg(`REG_BG);
        read_reg(`REG_CURVE);
        read_reg(`REG_AXES);
    endtask

    // random settings with junk in the unused bits
    task automatic randomize_settings(input int func);
        logic [31:0] d;
        d      = $urandom;
        d[1:0] = 2'(func);
        d[7:4] = 4'(3 + $urandom % 5);  // shift 3..7
        write_reg(`REG_CTRL, d);
        write_reg(`REG_BG, $urandom);
        write_reg(`REG_CURVE, $urandom);
        write_reg(`REG_AXES, $urandom);
    endtask

    task automatic bad_access();
        logic [3:0] a;
        a = 4'($urandom);
        if (a[1:0] == 2'b00)
            a[0] = 1'b1;            // off the word grid
        write_reg(a, $urandom);
        read_reg(a);
    endtask

    task automatic wait_for_row(input int f, input int row);
        do begin
            @(posedge clk_pix);
        end while (!(m_frame == f && m_y == row));
        #1;
    endtask

    // scan model and output compare at mid cycle
    always @(negedge clk_pix) begin
        logic [14:0] got;
        expect_t     e;
        got = {vga_hsync, vga_vsync, vga_de, vga_r, vga_g, vga_b};
        e   = '0;
        if (reset) begin
            if (got !== IDLE) begin
                vid_errs++;
                $display("ERR %0t: outputs not idle in reset, got %b", $time, got);
            end
            m_run   = 1'b0;
            m_x     = 0;
            m_y     = 0;
            m_frame = 0;
            exp_q.delete();
            e.v = IDLE;             // pipeline still flushing after reset
            for (int i = 0; i < `PLOT_LAT; i++)
                exp_q.push_back(e);
        end else begin
            if (m_run) begin
                if (m_x == `H_TOTAL - 1) begin
                    m_x = 0;
                    if (m_y == `V_TOTAL - 1) begin
                        m_y = 0;
                        m_frame++;
                    end else
                        m_y++;
                end else
                    m_x++;
            end
            m_run = 1'b1;
            if (m_x == 0 && m_y == 0) begin // live copy follows at frame start
                lv_func  = sh_func;
                lv_shift = sh_shift;
                lv_bg    = sh_bg;
                lv_curve = sh_curve;
                lv_axes  = sh_axes;
            end
            e.x = 12'(m_x);
            e.y = 12'(m_y);
            e.v = pixel_expect(m_x, m_y);
            exp_q.push_back(e);
            e = exp_q.pop_front();  // pixel from PLOT_LAT cycles back
            if (got !== e.v) begin
                vid_errs++;
                $display("ERR %0t: pixel (%0d,%0d) expected %b got %b", $time,
                         e.x, e.y, e.v, got);
            end
        end
    end

    initial begin
        int base;
        void'($urandom(54));
        vid_errs = 0;
        reg_errs = 0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        sh_func  = FUNC_OFF;
        sh_shift = '0;
        sh_bg    = '0;
        sh_curve = '0;
        sh_axes  = '0;
        reset    = 1'b1;
        repeat (2) @(posedge clk_pix);
        #1 reset = 1'b0;
        readback_all();             // reset values
        base = $urandom % 4;        // rotate so every function gets a frame
        for (int f = 0; f < RUN_FRAMES - 1; f++) begin
            // odd frames change mid screen and even frames in vertical blanking
            wait_for_row(f, (f % 2) ? 200 : 485);
            randomize_settings((base + f) % 4);
            if (f == 0 || $urandom % 3 != 0)
                bad_access();
            readback_all();
        end
        wait (m_frame == RUN_FRAMES);
        repeat (`PLOT_LAT + 2) @(posedge clk_pix);
        $display("errors: video %0d, register %0d", vid_errs, reg_errs);
        if (vid_errs == 0 && reg_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
graph_pkg.sv
display_timing.sv
graph_regs.sv
func_plot.sv
pixel_color.sv
graph_top.sv
tb_graph.sv

// File: Bender.yml
package:
  name: graph_video

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - graph_pkg.sv
      - display_timing.sv
      - graph_regs.sv
      - func_plot.sv
      - pixel_color.sv
      - graph_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_graph.sv
